// File: design/lspBuffer.sv
`default_nettype none

module lspBuffer import lspPkg::*; (
	input logic clk,
	input logic reset,
	input logic fillDone,
	input logic expandDone,
	input logic drainDone,
	output logic fillEnable,
	output logic expandStart,
	output logic drainStart,
	lspMemIf.buffer inPort,
	lspMemIf.buffer expPort,
	lspMemIf.buffer outPort
);

	logic [lspWidth-1:0] words [lspOrder];    // Frame store
	logic [lspWidth-1:0] rdData;
	logic [phaseWidth-1:0] phase;
	logic [addrWidth-1:0] rdAddr;
	logic [addrWidth-1:0] wrAddr;
	logic [lspWidth-1:0] wrData;
	logic wrEn;

	// Port owner follows the phase
	always_comb
	begin
		case (phase)
			phaseExpand:
			begin
				rdAddr = expPort.readAddr;
				wrAddr = expPort.writeAddr;
				wrData = expPort.writeData;
				wrEn = expPort.writeEn;
			end
			phaseDrain:
			begin
				rdAddr = outPort.readAddr;
				wrAddr = outPort.writeAddr;
				wrData = outPort.writeData;
				wrEn = outPort.writeEn;
			end
			default:
			begin
				rdAddr = inPort.readAddr;
				wrAddr = inPort.writeAddr;
				wrData = inPort.writeData;
				wrEn = inPort.writeEn;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (wrEn)
			words[wrAddr] <= wrData;
		rdData <= words[rdAddr];       // One cycle read latency
	end

	// Same read word seen by every client
	assign inPort.readData = rdData;
	assign expPort.readData = rdData;
	assign outPort.readData = rdData;

	////////////////////////////////////////////////////////////
	// Phase sequencing fill, expand, drain
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			phase <= phaseFill;
			expandStart <= 1'b0;
			drainStart <= 1'b0;
		end
		else
		begin
			expandStart <= 1'b0;
			drainStart <= 1'b0;
			case (phase)
				phaseFill:
					if (fillDone)
					begin
						phase <= phaseExpand;
						expandStart <= 1'b1;   // Pulse together with the change
					end
				phaseExpand:
					if (expandDone)
					begin
						phase <= phaseDrain;
						drainStart <= 1'b1;
					end
				phaseDrain:
					if (drainDone)
						phase <= phaseFill;
				default:
					phase <= phaseFill;
			endcase
		end
	end

	assign fillEnable = (phase == phaseFill);

endmodule

`default_nettype wire

// File: design/lspExpand.sv
`default_nettype none

module lspExpand import lspPkg::*; (
	input logic clk,
	input logic reset,
	input logic expandStart,
	output logic expandDone,
	lspMemIf.client mem
);

	logic [stateWidth-1:0] state;
	logic [stateWidth-1:0] nextState;
	logic [addrWidth-1:0] j;                // Loop index 1..9
	logic [lspWidth-1:0] bufPrev;           // buf[j-1] as read back
	logic [lspWidth-1:0] bufCur;            // buf[j]
	logic [lspWidth-1:0] tmp;
	logic [lspWidth-1:0] tmpNext;

	// tmp = shr(add(sub(buf[j-1], buf[j]), gap), 1)
	assign tmpNext = satShr(satAdd(satSub(bufPrev, mem.readData), lspWidth'(expandGap)),
		addrWidth'(1));

	////////////////////////////////////////////////////////////
	// Control registers
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= stIdle;
			j <= addrWidth'(1);
		end
		else
		begin
			state <= nextState;
			if (state == stIdle && expandStart)
				j <= addrWidth'(1);                  // Restart the walk
			else if (state == stCheck && tmp[lspWidth-1])
				j <= j + 1'b1;                       // Negative tmp, pair untouched
			else if (state == stWriteCur)
				j <= j + 1'b1;
		end
	end

	// Datapath captures
	always_ff @(posedge clk)
	begin
		if (state == stReadPrev)
			bufPrev <= mem.readData;
		if (state == stCalc)
		begin
			bufCur <= mem.readData;
			tmp <= tmpNext;
		end
	end

	////////////////////////////////////////////////////////////
	// Next state and buffer access
	////////////////////////////////////////////////////////////
	always_comb
	begin
		nextState = state;
		expandDone = 1'b0;
		mem.readAddr = '0;
		mem.writeAddr = '0;
		mem.writeData = '0;
		mem.writeEn = 1'b0;

		case (state)
			stIdle:
				if (expandStart)
					nextState = stLoop;

			// for (j = 1; j < lspOrder; j++)
			stLoop:
				if (j >= addrWidth'(lspOrder))
				begin
					expandDone = 1'b1;                 // All pairs spread
					nextState = stIdle;
				end
				else
				begin
					mem.readAddr = j - 1'b1;           // Fresh read of j-1
					nextState = stReadPrev;
				end

			stReadPrev:
			begin
				mem.readAddr = j;
				nextState = stCalc;
			end

			stCalc:
				nextState = stCheck;                   // tmp registered here

			// buf[j-1] = sub(buf[j-1], tmp) when tmp not negative
			stCheck:
				if (!tmp[lspWidth-1])
				begin
					mem.writeAddr = j - 1'b1;
					mem.writeData = satSub(bufPrev, tmp);
					mem.writeEn = 1'b1;
					nextState = stWriteCur;
				end
				else
					nextState = stLoop;

			// buf[j] = add(buf[j], tmp)
			stWriteCur:
			begin
				mem.writeAddr = j;
				mem.writeData = satAdd(bufCur, tmp);
				mem.writeEn = 1'b1;
				nextState = stLoop;
			end

			default:
				nextState = stIdle;
		endcase
	end

endmodule

`default_nettype wire

// File: design/lspInput.sv
`default_nettype none

module lspInput import lspPkg::*; (
	input logic clk,
	input logic reset,
	input logic lspValid,
	input logic [lspWidth-1:0] lspData,
	input logic fillEnable,           // Buffer is in the fill phase
	output logic lspCredit,
	output logic fillDone,
	lspMemIf.client mem
);

	logic [lspWidth-1:0] fifoMem [inCredits];   // Skid storage, no reset
	logic [fifoPtrWidth-1:0] headPtr;
	logic [fifoPtrWidth-1:0] tailPtr;
	logic [fifoPtrWidth:0] count;
	logic [addrWidth-1:0] wrIdx;                // Next buffer slot
	logic hold;                                 // Frame written, wait for phase turn
	logic push;
	logic pop;

	// Sender owns the credits, full only on a protocol breach
	assign push = lspValid && (count != (fifoPtrWidth + 1)'(inCredits));
	assign pop = fillEnable && !hold && (count != '0);

	////////////////////////////////////////////////////////////
	// Skid FIFO
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (push)
			fifoMem[tailPtr] <= lspData;
	end

	// Pointers wrap naturally, depth is a power of two
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			headPtr <= '0;
			tailPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				tailPtr <= tailPtr + 1'b1;
			if (pop)
				headPtr <= headPtr + 1'b1;
			count <= count + (fifoPtrWidth + 1)'(push) - (fifoPtrWidth + 1)'(pop);
		end
	end

	////////////////////////////////////////////////////////////
	// Frame fill
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wrIdx <= '0;
			hold <= 1'b0;
			lspCredit <= 1'b0;
			fillDone <= 1'b0;
		end
		else
		begin
			lspCredit <= pop;                  // One credit back per word stored
			fillDone <= 1'b0;
			if (!fillEnable)
				hold <= 1'b0;                  // Phase has moved on, rearm
			if (pop)
			begin
				if (wrIdx == addrWidth'(lspOrder - 1))
				begin
					wrIdx <= '0;
					hold <= 1'b1;
					fillDone <= 1'b1;          // Tenth word written
				end
				else
					wrIdx <= wrIdx + 1'b1;
			end
		end
	end

	// Write straight from the FIFO head
	assign mem.writeEn = pop;
	assign mem.writeAddr = wrIdx;
	assign mem.writeData = fifoMem[headPtr];
	assign mem.readAddr = '0;              // Write only port

endmodule

`default_nettype wire

// File: design/lspMemIf.sv
`default_nettype none

// One access port onto the frame buffer
interface lspMemIf import lspPkg::*; ();

	logic [addrWidth-1:0] readAddr;
	logic [lspWidth-1:0] readData;    // Valid one cycle after readAddr
	logic [addrWidth-1:0] writeAddr;
	logic [lspWidth-1:0] writeData;
	logic writeEn;                    // Takes effect at the clock edge

	// Frame store side
	modport buffer (
		input readAddr, writeAddr, writeData, writeEn,
		output readData
	);

	// Engine side
	modport client (
		output readAddr, writeAddr, writeData, writeEn,
		input readData
	);

endinterface

`default_nettype wire

// File: design/lspOutput.sv
`default_nettype none

module lspOutput import lspPkg::*; (
	input logic clk,
	input logic reset,
	input logic drainStart,
	output logic drainDone,
	input logic outCredit,
	output logic outValid,
	output logic [lspWidth-1:0] outData,
	lspMemIf.client mem
);

	logic active;                            // Draining a frame
	logic pending;                           // Read word arriving this cycle
	logic [addrWidth-1:0] rdPtr;             // Next address, pending word is rdPtr-1
	logic [addrWidth-1:0] readPtr;
	logic [outCreditWidth-1:0] credits;
	logic send;
	logic drop;
	logic issue;

	assign send = pending && (credits != '0);
	assign drop = pending && (credits == '0);          // Out of credits, fetch again
	assign issue = active && (drop || rdPtr != addrWidth'(lspOrder));
	assign readPtr = drop ? rdPtr - 1'b1 : rdPtr;

	assign mem.readAddr = issue ? readPtr : '0;
	assign mem.writeAddr = '0;                         // Read only port
	assign mem.writeData = '0;
	assign mem.writeEn = 1'b0;

	assign outValid = send;
	assign outData = mem.readData;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			active <= 1'b0;
			pending <= 1'b0;
			rdPtr <= '0;
			credits <= outCreditWidth'(outCredits);
			drainDone <= 1'b0;
		end
		else
		begin
			drainDone <= 1'b0;
			credits <= credits - outCreditWidth'(send) + outCreditWidth'(outCredit);
			if (drainStart)
			begin
				active <= 1'b1;
				pending <= 1'b0;
				rdPtr <= '0;
			end
			else if (active)
			begin
				pending <= issue;
				if (issue && !drop)
					rdPtr <= rdPtr + 1'b1;
				if (send && rdPtr == addrWidth'(lspOrder))
				begin
					active <= 1'b0;               // Word 9 just left
					drainDone <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: design/lspPkg.sv
`default_nettype none

package lspPkg;

	////////////////////////////////////////////////////////////
	// Frame and word sizes
	////////////////////////////////////////////////////////////
	localparam int lspOrder = 10;                 // Coefficients per frame
	localparam int lspWidth = 16;                 // Q13 coefficient width
	localparam int addrWidth = 4;                 // Covers indices 0..9
	localparam int expandGap = 10;                // Minimum spacing target

	// Credit counts after reset
	localparam int inCredits = 4;                 // Also the skid FIFO depth
	localparam int outCredits = 4;
	localparam int fifoPtrWidth = $clog2(inCredits);
	localparam int outCreditWidth = $clog2(outCredits + 1);

	// Saturation limits
	localparam logic [lspWidth-1:0] satMax = 16'h7FFF;
	localparam logic [lspWidth-1:0] satMin = 16'h8000;

	// Buffer ownership phases
	localparam int phaseWidth = 2;
	localparam logic [phaseWidth-1:0] phaseFill = 2'd0;
	localparam logic [phaseWidth-1:0] phaseExpand = 2'd1;
	localparam logic [phaseWidth-1:0] phaseDrain = 2'd2;

	// Expansion FSM encoding
	localparam int stateWidth = 3;
	localparam logic [stateWidth-1:0] stIdle = 3'd0;
	localparam logic [stateWidth-1:0] stLoop = 3'd1;      // Loop test on j
	localparam logic [stateWidth-1:0] stReadPrev = 3'd2;  // buf[j-1] arrives
	localparam logic [stateWidth-1:0] stCalc = 3'd3;      // buf[j] arrives, tmp formed
	localparam logic [stateWidth-1:0] stCheck = 3'd4;     // Sign test, write j-1
	localparam logic [stateWidth-1:0] stWriteCur = 3'd5;  // Write j

	////////////////////////////////////////////////////////////
	// Saturating 16-bit arithmetic
	////////////////////////////////////////////////////////////
	function automatic logic [lspWidth-1:0] satAdd(input logic [lspWidth-1:0] a,
		input logic [lspWidth-1:0] b);
		logic [lspWidth:0] sum;
		sum = {a[lspWidth-1], a} + {b[lspWidth-1], b};  // One guard bit
		if (sum[lspWidth] != sum[lspWidth-1])
			return sum[lspWidth] ? satMin : satMax;     // Overflow clamps
		return sum[lspWidth-1:0];
	endfunction

	function automatic logic [lspWidth-1:0] satSub(input logic [lspWidth-1:0] a,
		input logic [lspWidth-1:0] b);
		logic [lspWidth:0] diff;
		diff = {a[lspWidth-1], a} - {b[lspWidth-1], b};
		if (diff[lspWidth] != diff[lspWidth-1])
			return diff[lspWidth] ? satMin : satMax;
		return diff[lspWidth-1:0];
	endfunction

	// Arithmetic shift, sign fills from the top
	function automatic logic [lspWidth-1:0] satShr(input logic [lspWidth-1:0] a,
		input logic [addrWidth-1:0] shift);
		return $signed(a) >>> shift;
	endfunction

endpackage

`default_nettype wire

// File: design/lspStabilizer.sv
`default_nettype none

module lspStabilizer import lspPkg::*; (
	input logic clk,
	input logic reset,
	input logic lspValid,
	input logic [lspWidth-1:0] lspData,
	output logic lspCredit,
	output logic outValid,
	output logic [lspWidth-1:0] outData,
	input logic outCredit
);

	logic fillEnable;
	logic fillDone;
	logic expandStart;
	logic expandDone;
	logic drainStart;
	logic drainDone;

	// One buffer port per phase owner
	lspMemIf inBus ();
	lspMemIf expBus ();
	lspMemIf outBus ();

	////////////////////////////////////////////////////////////
	// Input side, engine, output side around the buffer
	////////////////////////////////////////////////////////////
	lspInput inputSide (
		.clk(clk),
		.reset(reset),
		.lspValid(lspValid),
		.lspData(lspData),
		.fillEnable(fillEnable),
		.lspCredit(lspCredit),
		.fillDone(fillDone),
		.mem(inBus.client)
	);

	lspBuffer frameBuffer (
		.clk(clk),
		.reset(reset),
		.fillDone(fillDone),
		.expandDone(expandDone),
		.drainDone(drainDone),
		.fillEnable(fillEnable),
		.expandStart(expandStart),
		.drainStart(drainStart),
		.inPort(inBus.buffer),
		.expPort(expBus.buffer),
		.outPort(outBus.buffer)
	);

	lspExpand expandEngine (
		.clk(clk),
		.reset(reset),
		.expandStart(expandStart),
		.expandDone(expandDone),
		.mem(expBus.client)
	);

	lspOutput outputSide (
		.clk(clk),
		.reset(reset),
		.drainStart(drainStart),
		.drainDone(drainDone),
		.outCredit(outCredit),
		.outValid(outValid),
		.outData(outData),
		.mem(outBus.client)
	);

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Build and run the LSP stabilizer testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tbLspStabilizer -f tb.f \
	&& ./obj_dir/VtbLspStabilizer +verilator+error+limit+1000 > sim.log 2>&1 \
	|| echo "Build or simulation returned an error"

cat sim.log 2>/dev/null
grep -q "TEST PASSED" sim.log 2>/dev/null && echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// File: tb.f
design/lspPkg.sv
design/lspMemIf.sv
design/lspInput.sv
design/lspBuffer.sv
design/lspExpand.sv
design/lspOutput.sv
design/lspStabilizer.sv
tb/tbClock.sv
tb/lspStabilizer_assertions.sv
tb/tbChecker.sv
tb/tbLspStabilizer.sv

// File: tb/lspStabilizer_assertions.sv
`default_nettype none

module lspStabilizerAssertions import lspPkg::*; (
	input logic clk,
	input logic reset,
	input logic lspValid,
	input logic lspCredit,
	input logic outValid,
	input logic outCredit
);

	int senderCredits;     // Credits the upstream sender holds
	int outHeld;           // Credits the output side holds
	int outFails = 0;
	int returnFails = 0;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			senderCredits <= inCredits;
			outHeld <= outCredits;
		end
		else
		begin
			senderCredits <= senderCredits - int'(lspValid) + int'(lspCredit);
			outHeld <= outHeld - int'(outValid) + int'(outCredit);
		end
	end

	////////////////////////////////////////////////////////////
	// Credit rules on both streams
	////////////////////////////////////////////////////////////
	outWithinCredit: assert property (@(posedge clk) disable iff (reset)
		outValid |-> outHeld > 0)
	else
	begin
		outFails++;
		$error("outValid high with no downstream credit held");
	end

	// Returned credits never top the starting count
	returnWithinLimit: assert property (@(posedge clk) disable iff (reset)
		senderCredits <= inCredits)
	else
	begin
		returnFails++;
		$error("lspCredit returned more credits than the sender started with");
	end

endmodule

bind lspStabilizer lspStabilizerAssertions protocolAssertions (
	.clk(clk),
	.reset(reset),
	.lspValid(lspValid),
	.lspCredit(lspCredit),
	.outValid(outValid),
	.outCredit(outCredit)
);

`default_nettype wire

// File: tb/tbChecker.sv
`default_nettype none

module tbChecker import lspPkg::*; (
	input logic clk,
	input logic reset,
	input logic lspValid,
	input logic [lspWidth-1:0] lspData,
	input logic lspCredit,
	input logic outValid,
	input logic [lspWidth-1:0] outData,
	input logic outCredit,
	input logic runDone,                       // Stimulus over, close the books
	output int errorCount,
	output int framesOut
);

	logic [lspWidth-1:0] inFrame [lspOrder];    // Frame being collected
	logic [lspWidth-1:0] expected [$];          // Model output in send order
	logic [lspWidth-1:0] want;
	int inIdx;
	int outIdx;
	int wordsIn;
	int creditsBack;
	int heldOut;                                // Downstream credits at the DUT
	int framesIn;
	bit closed;

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////
	function automatic logic [lspWidth-1:0] clampWord(input int value);
		if (value > 32767)
			return 16'h7fff;
		if (value < -32768)
			return 16'h8000;
		return lspWidth'(value);
	endfunction

	function automatic int wordToInt(input logic [lspWidth-1:0] word);
		return int'($signed(word));
	endfunction

	// Spread each pair j-1, j in turn and queue the result
	task automatic expandFrame();
		int a;
		int b;
		int d;
		int s;
		int t;
		int j;
		for (j = 1; j < lspOrder; j++)
		begin
			a = wordToInt(inFrame[j-1]);              // Already moved by step j-1
			b = wordToInt(inFrame[j]);
			d = wordToInt(clampWord(a - b));
			s = wordToInt(clampWord(d + expandGap));
			t = s >>> 1;                              // Floor halving
			if (t >= 0)
			begin
				inFrame[j-1] = clampWord(a - t);
				inFrame[j] = clampWord(b + t);
			end
		end
		for (j = 0; j < lspOrder; j++)
			expected.push_back(inFrame[j]);
		framesIn++;
	endtask

	////////////////////////////////////////////////////////////
	// Stream watch
	////////////////////////////////////////////////////////////
	always @(posedge clk)
	begin
		if (reset)
		begin
			inIdx = 0;
			outIdx = 0;
			wordsIn = 0;
			creditsBack = 0;
			heldOut = outCredits;
			framesIn = 0;
			framesOut = 0;
			errorCount = 0;
			closed = 1'b0;
			expected.delete();
		end
		else
		begin
			if (lspValid)
			begin
				inFrame[inIdx] = lspData;
				wordsIn++;
				if (inIdx == lspOrder - 1)
				begin
					expandFrame();                    // Tenth word in
					inIdx = 0;
				end
				else
					inIdx++;
			end

			if (lspCredit)
			begin
				creditsBack++;
				if (creditsBack > wordsIn)
				begin
					$display("Error at time %0t: lspCredit pulsed with no word stored", $time);
					errorCount++;
				end
			end

			if (outValid)
			begin
				if (heldOut == 0)
				begin
					$display("Error at time %0t: outValid high with no credit held", $time);
					errorCount++;
				end
				if (expected.size() == 0)
				begin
					$display("Error at time %0t: outValid high with no frame pending", $time);
					errorCount++;
				end
				else
				begin
					want = expected.pop_front();
					if (outData !== want)
					begin
						$display("Fail at time %0t: outData frame %0d word %0d expected %h, got %h",
							$time, framesOut, outIdx, want, outData);
						errorCount++;
					end
					outIdx++;
					if (outIdx == lspOrder)
					begin
						outIdx = 0;
						framesOut++;
					end
				end
			end
			heldOut = heldOut - int'(outValid) + int'(outCredit);

			// End of run totals
			if (runDone && !closed)
			begin
				closed = 1'b1;
				if (creditsBack != wordsIn)
				begin
					$display("Fail at time %0t: lspCredit pulse count expected %0d, got %0d",
						$time, wordsIn, creditsBack);
					errorCount++;
				end
				if (framesOut != framesIn)
				begin
					$display("Fail at time %0t: output frame count expected %0d, got %0d",
						$time, framesIn, framesOut);
					errorCount++;
				end
				if (inIdx != 0 || outIdx != 0)
				begin
					$display("Error at time %0t: a frame was left incomplete", $time);
					errorCount++;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: tb/tbClock.sv
`default_nettype none

module tbClock (
	output logic clk
);

	localparam int halfPeriod = 4;   // Full period of 8

	initial
	begin
		clk = 1'b0;
		forever #halfPeriod clk = ~clk;
	end

endmodule

`default_nettype wire

// File: tb/tbLspStabilizer.sv
`default_nettype none

module tbLspStabilizer import lspPkg::*; ();

	localparam int frameCount = 20;
	localparam int resetCycles = 10;
	localparam int idleCycles = 20;             // Quiet stretch after reset
	localparam int sendTimeout = 500;
	localparam int drainTimeout = 3000;
	localparam logic [31:0] lfsrSeed = 32'hcc0c_f659;
	localparam logic [31:0] lfsrTaps = 32'h8020_0003;

	logic clk;
	logic reset;
	logic lspValid;
	logic [lspWidth-1:0] lspData;
	logic lspCredit;
	logic outValid;
	logic [lspWidth-1:0] outData;
	logic outCredit;
	logic runDone;
	int checkErrors;
	int framesOut;
	logic [31:0] lfsrState;
	int upCredits;                              // Sender side credit count
	int owed;                                   // Words taken with credit still owed
	int withholdLeft;                           // Consumer stall cycles left
	int timeoutCount;
	bit aborted;

	tbClock clockGen (.clk(clk));

	lspStabilizer DUT (
		.clk(clk),
		.reset(reset),
		.lspValid(lspValid),
		.lspData(lspData),
		.lspCredit(lspCredit),
		.outValid(outValid),
		.outData(outData),
		.outCredit(outCredit)
	);

	tbChecker scoreboard (
		.clk(clk),
		.reset(reset),
		.lspValid(lspValid),
		.lspData(lspData),
		.lspCredit(lspCredit),
		.outValid(outValid),
		.outData(outData),
		.outCredit(outCredit),
		.runDone(runDone),
		.errorCount(checkErrors),
		.framesOut(framesOut)
	);

	////////////////////////////////////////////////////////////
	// Random source and frame shapes
	////////////////////////////////////////////////////////////
	function automatic logic [31:0] randomBits(input int n);
		logic [31:0] value;
		int i;
		value = '0;
		for (i = 0; i < n; i++)
		begin
			lfsrState = lfsrState[0] ? (lfsrState >> 1) ^ lfsrTaps : lfsrState >> 1;
			value = {value[30:0], lfsrState[0]};
		end
		return value;
	endfunction

	// Wide sorted, random, close or inverted, near full scale
	function automatic logic [lspWidth-1:0] makeWord(input int kind, input int index,
		input int prev);
		int v;
		case (kind)
			0: v = (index == 0) ? -20000 + int'(randomBits(10)) : prev + 10 + int'(randomBits(8));
			1: v = int'(randomBits(16));
			2: v = (index == 0) ? -4000 + int'(randomBits(13)) : prev + int'(randomBits(5)) - 8;
			default: v = randomBits(1) ? 32767 - int'(randomBits(4)) : -32768 + int'(randomBits(4));
		endcase
		return lspWidth'(v);
	endfunction

	////////////////////////////////////////////////////////////
	// One clock of stimulus on both streams
	////////////////////////////////////////////////////////////
	task automatic stepCycle(input logic wantSend, input logic [lspWidth-1:0] word,
		output logic sent);
		@(posedge clk);
		#1;
		if (lspCredit)
			upCredits++;                            // Word left the skid FIFO
		if (outValid)
			owed++;                                 // Transfers at the next edge
		if (withholdLeft > 0)
		begin
			withholdLeft--;
			outCredit = 1'b0;
		end
		else if (owed > 0 && randomBits(1) == 1)
		begin
			owed--;
			outCredit = 1'b1;
		end
		else
			outCredit = 1'b0;
		if (withholdLeft == 0 && randomBits(5) == 0)
			withholdLeft = 8 + int'(randomBits(5)); // Start a consumer stall
		sent = wantSend && upCredits > 0 && randomBits(2) != 0;
		lspValid = sent;
		lspData = sent ? word : '0;
		if (sent)
			upCredits--;
	endtask

	task automatic sendWord(input logic [lspWidth-1:0] word);
		logic sent;
		int waited;
		sent = 1'b0;
		waited = 0;
		while (!sent && waited < sendTimeout)
		begin
			stepCycle(1'b1, word, sent);
			waited++;
		end
		if (!sent)
		begin
			$display("Timeout at time %0t: no upstream credit came back in %0d cycles",
				$time, sendTimeout);
			timeoutCount++;
			aborted = 1'b1;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////
	initial
	begin
		logic sent;
		logic [lspWidth-1:0] word;
		int waited;
		int prev;
		int assertFails;
		lfsrState = lfsrSeed;
		reset = 1'b1;
		lspValid = 1'b0;
		lspData = '0;
		outCredit = 1'b0;
		runDone = 1'b0;
		upCredits = inCredits;
		owed = 0;
		withholdLeft = 0;
		timeoutCount = 0;
		aborted = 1'b0;

		repeat (resetCycles) @(posedge clk);
		#1;
		reset = 1'b0;
		repeat (idleCycles) stepCycle(1'b0, '0, sent);   // Outputs must stay quiet

		for (int f = 0; f < frameCount && !aborted; f++)
		begin
			prev = 0;
			for (int i = 0; i < lspOrder && !aborted; i++)
			begin
				word = makeWord(f % 4, i, prev);
				prev = int'($signed(word));
				sendWord(word);
			end
		end

		// Let the last frames drain
		waited = 0;
		while (!aborted && framesOut < frameCount && waited < drainTimeout)
		begin
			stepCycle(1'b0, '0, sent);
			waited++;
		end
		if (!aborted && framesOut < frameCount)
		begin
			$display("Timeout at time %0t: only %0d of %0d frames came out",
				$time, framesOut, frameCount);
			timeoutCount++;
		end

		runDone = 1'b1;
		repeat (3) stepCycle(1'b0, '0, sent);

		assertFails = DUT.protocolAssertions.outFails + DUT.protocolAssertions.returnFails;
		$display("Closing: %0d check errors, %0d assertion failures, %0d timeouts, %0d frames",
			checkErrors, assertFails, timeoutCount, framesOut);
		if (checkErrors == 0 && assertFails == 0 && timeoutCount == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire
